//--- alu.sv
module alu import cpu_pkg::*; (
	input ctrl_t ctrl,
	input instr_t instr,
	input logic [word_size-1:0] pc,
	input logic [word_size-1:0] reg_a,
	input logic [word_size-1:0] reg_b,
	output logic [word_size-1:0] result,
	output logic bcond
);

	logic [word_size-1:0] instr_bits;
	logic [imm_width-1:0] imm;
	logic [word_size-1:0] imm_ext;
	logic [word_size-1:0] op_a;
	logic [word_size-1:0] op_b;
	logic regs_equal;

	assign instr_bits = instr;
	assign imm = instr_bits[imm_width-1:0];

	// ori zero extends, everything else sign extends
	assign imm_ext = (instr.opcode == op_ori) ?
		{{(word_size-imm_width){1'b0}}, imm} :
		{{(word_size-imm_width){imm[imm_width-1]}}, imm};

	assign op_a = ctrl.alu_src_a_pc ? pc : reg_a;

	always_comb begin
		case (ctrl.alu_src_b)
			src_b_reg: op_b = reg_b;
			src_b_one: op_b = {{(word_size-1){1'b0}}, 1'b1};
			src_b_imm: op_b = imm_ext;
			default: op_b = '0;
		endcase
	end

	always_comb begin
		case (ctrl.alu_func)
			alu_add: result = op_a + op_b;
			alu_sub: result = op_a - op_b;
			alu_and: result = op_a & op_b;
			alu_or: result = op_a | op_b;
			alu_not: result = ~op_a;
			alu_lhi: result = {op_b[imm_width-1:0], {(word_size-imm_width){1'b0}}};
			default: result = op_b;
		endcase
	end

	// separate compare, the adder is busy with the branch target
	assign regs_equal = (reg_a == reg_b);

	always_comb begin
		case (instr.opcode)
			op_beq: bcond = regs_equal;
			op_bne: bcond = !regs_equal;
			default: bcond = 1'b0;
		endcase
	end

endmodule

//--- control_unit.sv
module control_unit import cpu_pkg::*; (
	input logic clk,
	input logic reset_n,
	input instr_t instr,
	output ctrl_t ctrl,
	output logic is_halted
);

	state_t state;
	state_t next_state;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state <= st_if;
		end else begin
			state <= next_state;
		end
	end

	assign is_halted = (state == st_halted);

	always_comb begin
		next_state = state;
		ctrl = '0;
		ctrl.alu_func = alu_pass_b;
		ctrl.alu_src_b = src_b_reg;

		case (state)
			st_if: begin
				// fetch and pc + 1 through the alu
				ctrl.mem_read = 1'b1;
				ctrl.ir_write = 1'b1;
				ctrl.alu_src_a_pc = 1'b1;
				ctrl.alu_src_b = src_b_one;
				ctrl.alu_func = alu_add;
				ctrl.pc_write = 1'b1;
				next_state = st_id;
			end

			st_id: begin
				case (instr.opcode)
					op_jmp: begin
						ctrl.pc_write = 1'b1;
						ctrl.pc_jump = 1'b1;
						ctrl.new_inst = 1'b1;
						next_state = st_if;
					end
					op_rtype: begin
						case (instr.func)
							fn_add, fn_sub, fn_and, fn_orr, fn_not: begin
								next_state = st_ex;
							end
							fn_wwd: begin
								ctrl.wwd = 1'b1;
								ctrl.new_inst = 1'b1;
								next_state = st_if;
							end
							fn_hlt: begin
								ctrl.new_inst = 1'b1;
								next_state = st_halted;
							end
							default: begin
								// unknown function treated as nop
								ctrl.new_inst = 1'b1;
								next_state = st_if;
							end
						endcase
					end
					op_adi, op_ori, op_lhi, op_lwd, op_swd, op_bne, op_beq: begin
						next_state = st_ex;
					end
					default: begin
						ctrl.new_inst = 1'b1;
						next_state = st_if;
					end
				endcase
			end

			st_ex: begin
				case (instr.opcode)
					op_rtype: begin
						case (instr.func)
							fn_sub: ctrl.alu_func = alu_sub;
							fn_and: ctrl.alu_func = alu_and;
							fn_orr: ctrl.alu_func = alu_or;
							fn_not: ctrl.alu_func = alu_not;
							default: ctrl.alu_func = alu_add;
						endcase
						next_state = st_wb;
					end
					op_adi, op_ori, op_lhi: begin
						ctrl.alu_src_b = src_b_imm;
						ctrl.alu_func = (instr.opcode == op_adi) ? alu_add :
							(instr.opcode == op_ori) ? alu_or : alu_lhi;
						next_state = st_wb;
					end
					op_lwd, op_swd: begin
						// effective address rs + imm
						ctrl.alu_src_b = src_b_imm;
						ctrl.alu_func = alu_add;
						next_state = st_mem;
					end
					op_bne, op_beq: begin
						// target from pc already incremented
						ctrl.alu_src_a_pc = 1'b1;
						ctrl.alu_src_b = src_b_imm;
						ctrl.alu_func = alu_add;
						ctrl.pc_branch = 1'b1;
						ctrl.new_inst = 1'b1;
						next_state = st_if;
					end
					default: begin
						ctrl.new_inst = 1'b1;
						next_state = st_if;
					end
				endcase
			end

			st_mem: begin
				ctrl.addr_from_alu = 1'b1;
				if (instr.opcode == op_lwd) begin
					ctrl.mem_read = 1'b1;
					next_state = st_wb;
				end else begin
					ctrl.mem_write = 1'b1;
					ctrl.new_inst = 1'b1;
					next_state = st_if;
				end
			end

			st_wb: begin
				ctrl.reg_write = 1'b1;
				ctrl.mem_to_reg = (instr.opcode == op_lwd);
				ctrl.new_inst = 1'b1;
				next_state = st_if;
			end

			// stays here until reset, all strobes low
			st_halted: next_state = st_halted;

			default: next_state = st_if;
		endcase
	end

endmodule

//--- cpu.sv
module cpu import cpu_pkg::*; (
	input logic clk,
	input logic reset_n,
	output logic read_m,
	output logic write_m,
	output logic [word_size-1:0] address,
	inout wire [word_size-1:0] data,
	output logic [word_size-1:0] num_inst,
	output logic [word_size-1:0] output_port,
	output logic is_halted
);

	ctrl_t ctrl;
	instr_t instr;
	logic [word_size-1:0] instr_bits;

	logic [word_size-1:0] pc;
	logic [word_size-1:0] pc_next;
	logic [word_size-1:0] jump_target;

	logic [word_size-1:0] alu_result;
	logic [word_size-1:0] alu_out_q;
	logic bcond;

	logic [word_size-1:0] mem_data;
	logic [word_size-1:0] reg_a;
	logic [word_size-1:0] reg_b;
	logic [word_size-1:0] wb_data;
	logic [reg_addr_width-1:0] wb_reg;

	assign instr_bits = instr;

	// pc high nibble kept on jumps
	assign jump_target = {pc[word_size-1:target_width], instr_bits[target_width-1:0]};
	assign pc_next = ctrl.pc_jump ? jump_target : alu_result;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			pc <= '0;
			num_inst <= '0;
			output_port <= '0;
		end else begin
			if (ctrl.pc_write || (ctrl.pc_branch && bcond)) begin
				pc <= pc_next;
			end
			if (ctrl.new_inst) begin
				num_inst <= num_inst + 1'b1;
			end
			if (ctrl.wwd) begin
				output_port <= reg_a;
			end
		end
	end

	// alu result held for MEM and WB
	always_ff @(posedge clk) begin
		alu_out_q <= alu_result;
	end

	assign wb_data = ctrl.mem_to_reg ? mem_data : alu_out_q;
	// rd for r-type, rt for i-type
	assign wb_reg = (instr.opcode == op_rtype) ? instr.rd : instr.rt;

	mem_bus_if mem_bus_i (
		.clk(clk),
		.reset_n(reset_n),
		.ctrl(ctrl),
		.pc(pc),
		.alu_result(alu_out_q),
		.store_data(reg_b),
		.address(address),
		.read_m(read_m),
		.write_m(write_m),
		.data(data),
		.instr(instr),
		.mem_data(mem_data)
	);

	control_unit control_i (
		.clk(clk),
		.reset_n(reset_n),
		.instr(instr),
		.ctrl(ctrl),
		.is_halted(is_halted)
	);

	register_file regs_i (
		.clk(clk),
		.reset_n(reset_n),
		.read1(instr.rs),
		.read2(instr.rt),
		.write_reg(wb_reg),
		.write_data(wb_data),
		.write_en(ctrl.reg_write),
		.read_out1(reg_a),
		.read_out2(reg_b)
	);

	alu alu_i (
		.ctrl(ctrl),
		.instr(instr),
		.pc(pc),
		.reg_a(reg_a),
		.reg_b(reg_b),
		.result(alu_result),
		.bcond(bcond)
	);

endmodule

//--- cpu_assert.sv
module cpu_assert (
	input logic clk,
	input logic reset_n,
	input logic read_m,
	input logic write_m,
	input logic is_halted
);

	timeunit 1ns;
	timeprecision 1ps;

	// one strobe at a time on the shared bus
	strobes_exclusive: assert property (@(posedge clk) disable iff (!reset_n)
		!(read_m && write_m))
		else $error("read_m and write_m high in the same cycle");

	halt_quiet: assert property (@(posedge clk) disable iff (!reset_n)
		is_halted |-> !read_m && !write_m)
		else $error("memory strobe raised while halted");

	// only reset leaves the halted state
	halt_sticky: assert property (@(posedge clk) disable iff (!reset_n)
		is_halted |=> is_halted)
		else $error("is_halted dropped without a reset");

endmodule

bind cpu cpu_assert cpu_assert_i (
	.clk(clk),
	.reset_n(reset_n),
	.read_m(read_m),
	.write_m(write_m),
	.is_halted(is_halted)
);

//--- cpu_pkg.sv
package cpu_pkg;

	// data and address width
	localparam int word_size = 16;
	localparam int imm_width = 8;
	localparam int target_width = 12;
	localparam int reg_addr_width = 2;
	localparam int num_regs = 4;

	typedef enum logic [3:0] {
		op_bne = 4'd0,
		op_beq = 4'd1,
		op_adi = 4'd4,
		op_ori = 4'd5,
		op_lhi = 4'd6,
		op_lwd = 4'd7,
		op_swd = 4'd8,
		op_jmp = 4'd9,
		op_rtype = 4'd15
	} opcode_t;

	// function field of r-type words
	typedef enum logic [5:0] {
		fn_add = 6'd0,
		fn_sub = 6'd1,
		fn_and = 6'd2,
		fn_orr = 6'd3,
		fn_not = 6'd4,
		fn_wwd = 6'd28,
		fn_hlt = 6'd29
	} func_t;

	// imm8 is {rd, func}, jump target is {rs, rt, rd, func}
	typedef struct packed {
		opcode_t opcode;
		logic [reg_addr_width-1:0] rs;
		logic [reg_addr_width-1:0] rt;
		logic [reg_addr_width-1:0] rd;
		func_t func;
	} instr_t;

	typedef enum logic [2:0] {
		st_if,
		st_id,
		st_ex,
		st_mem,
		st_wb,
		st_halted
	} state_t;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_not,
		alu_lhi,
		alu_pass_b
	} alu_func_t;

	typedef enum logic [1:0] {
		src_b_reg,
		src_b_one,
		src_b_imm
	} alu_src_b_t;

	// per-cycle control bundle from the fsm
	typedef struct packed {
		logic pc_write;
		logic pc_branch;
		logic pc_jump;
		logic ir_write;
		logic mem_read;
		logic mem_write;
		logic addr_from_alu;
		logic reg_write;
		logic mem_to_reg;
		logic wwd;
		logic new_inst;
		alu_src_b_t alu_src_b;
		logic alu_src_a_pc;
		alu_func_t alu_func;
	} ctrl_t;

endpackage

//--- filelist.f
cpu_pkg.sv
mem_bus_if.sv
control_unit.sv
register_file.sv
alu.sv
cpu.sv
cpu_assert.sv
tb_cpu.sv

//--- mem_bus_if.sv
module mem_bus_if import cpu_pkg::*; (
	input logic clk,
	input logic reset_n,
	input ctrl_t ctrl,
	input logic [word_size-1:0] pc,
	input logic [word_size-1:0] alu_result,
	input logic [word_size-1:0] store_data,
	output logic [word_size-1:0] address,
	output logic read_m,
	output logic write_m,
	inout wire [word_size-1:0] data,
	output instr_t instr,
	output logic [word_size-1:0] mem_data
);

	logic [word_size-1:0] write_data_q;

	// fetch from pc, data accesses from the registered alu result
	assign address = ctrl.addr_from_alu ? alu_result : pc;

	assign read_m = ctrl.mem_read;
	assign write_m = ctrl.mem_write;

	// bus released unless writing
	assign data = (!read_m && write_m) ? write_data_q : {word_size{1'bz}};

	// instruction register
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			instr <= '0;
		end else if (ctrl.ir_write) begin
			instr <= instr_t'(data);
		end
	end

	always_ff @(posedge clk) begin
		// data reads only, fetches go to the instruction register
		if (ctrl.mem_read && !ctrl.ir_write) begin
			mem_data <= data;
		end
		// rt value captured in EX, stable through MEM
		write_data_q <= store_data;
	end

endmodule

//--- register_file.sv
module register_file import cpu_pkg::*; (
	input logic clk,
	input logic reset_n,
	input logic [1:0] read1,
	input logic [1:0] read2,
	input logic [1:0] write_reg,
	input logic [word_size-1:0] write_data,
	input logic write_en,
	output logic [word_size-1:0] read_out1,
	output logic [word_size-1:0] read_out2
);

	logic [word_size-1:0] regs [num_regs];

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			for (int i = 0; i < num_regs; i++) begin
				regs[i] <= '0;
			end
		end else if (write_en) begin
			regs[write_reg] <= write_data;
		end
	end

	// asynchronous reads
	assign read_out1 = regs[read1];
	assign read_out2 = regs[read2];

endmodule

//--- run_sim.sh
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
	--top-module tb_cpu -f filelist.f || { echo "build failed"; exit 1; }
./obj_dir/Vtb_cpu > sim.log 2>&1
cat sim.log
grep -q "Simulation finished: FAIL" sim.log && exit 1
grep -q "Simulation finished: PASS" sim.log || exit 1
exit 0

//--- tb_cpu.sv
module tb_cpu import cpu_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	// 200 random instructions and the closing hlt
	localparam int prog_len = 201;
	localparam int max_cycles = 5 * prog_len + 100;

	logic clk = 1'b0;
	logic reset_n;
	wire [word_size-1:0] data;
	logic read_m;
	logic write_m;
	logic is_halted;
	logic [word_size-1:0] address;
	logic [word_size-1:0] num_inst;
	logic [word_size-1:0] output_port;

	logic [word_size-1:0] mem [256];
	logic [word_size-1:0] ref_mem [256];
	logic [word_size-1:0] regs [4];
	bit group_start [prog_len];

	// expected trace with one entry per executed instruction
	logic [word_size-1:0] exp_pc [$];
	logic [word_size-1:0] exp_word [$];
	logic [word_size-1:0] exp_port [$];
	int exp_cycles [$];
	bit exp_after_load [$];
	logic [word_size-1:0] exp_store_addr [$];
	logic [word_size-1:0] exp_store_data [$];

	int checks [6];
	int errors [6];
	string test_name [6] = '{"arith", "stores", "loads", "control flow", "cycle counts", "halt"};
	int cycle_count = 0;

	always #5 clk = ~clk;

	// memory answers in the same cycle and writes on the edge
	assign data = read_m ? mem[address[7:0]] : 'z;

	always @(posedge clk) begin
		if (write_m) begin
			mem[address[7:0]] = data;
		end
	end

	cpu cpu_i (
		.clk(clk),
		.reset_n(reset_n),
		.read_m(read_m),
		.write_m(write_m),
		.address(address),
		.data(data),
		.num_inst(num_inst),
		.output_port(output_port),
		.is_halted(is_halted)
	);

	function automatic logic [15:0] sign_extend(input logic [7:0] imm);
		return {{8{imm[7]}}, imm};
	endfunction

	function automatic logic [15:0] encode_word(input logic [3:0] op, input logic [1:0] rs,
		input logic [1:0] rt, input logic [7:0] low);
		return {op, rs, rt, low};
	endfunction

	task automatic expect_equal(input int t, input string name, input logic [15:0] exp,
		input logic [15:0] act);
		checks[t]++;
		assert (act === exp) else begin
			errors[t]++;
			$display("FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
		end
	endtask

	task automatic require(input int t, input bit ok, input string what);
		checks[t]++;
		assert (ok) else begin
			errors[t]++;
			$display("error at %0t: %s", $time, what);
		end
	endtask

	task automatic report_test(input int t);
		$display("test %s: %0d checks, %0d errors", test_name[t], checks[t], errors[t]);
	endtask

	task automatic build_program();
		int slot;
		int kind;
		int t;
		logic [1:0] b;
		logic [1:0] r;
		slot = 0;
		for (int a = 0; a < 256; a++) begin
			mem[a] = 16'(a * 40503) ^ 16'h5a3c;
		end
		while (slot < prog_len - 1) begin
			group_start[slot] = 1'b1;
			kind = int'($urandom_range(0, 9));
			b = 2'($urandom_range(0, 3));
			r = 2'($urandom_range(0, 3));
			if (kind == 8 && slot + 4 < prog_len) begin
				// base register set to 128, then load and show
				mem[slot] = encode_word(op_lhi, 2'd0, b, 8'h00);
				mem[slot + 1] = encode_word(op_ori, b, b, 8'h80);
				mem[slot + 2] = encode_word(op_lwd, b, r, 8'($urandom_range(0, 127)));
				mem[slot + 3] = encode_word(op_rtype, r, 2'd0, {2'd0, 6'd28});
				slot += 4;
			end else if (kind == 9 && slot + 3 < prog_len) begin
				// stores stay above the code image
				mem[slot] = encode_word(op_lhi, 2'd0, b, 8'h00);
				mem[slot + 1] = encode_word(op_ori, b, b, 8'h80);
				mem[slot + 2] = encode_word(op_swd, b, r, 8'($urandom_range(73, 127)));
				slot += 3;
			end else begin
				if (kind == 7)
					mem[slot] = encode_word(op_jmp, 2'd0, 2'd0, 8'h00);
				else if (kind == 6)
					mem[slot] = encode_word(4'($urandom_range(0, 1)), b, r, 8'h00);
				else if (kind == 5)
					mem[slot] = encode_word(op_rtype, b, 2'd0, {2'd0, 6'd28});
				else if (kind >= 3)
					mem[slot] = encode_word(4'(4 + $urandom_range(0, 2)), b, r, 8'($urandom));
				else
					mem[slot] = encode_word(op_rtype, b, r, {2'($urandom), 6'($urandom_range(0, 4))});
				slot++;
			end
		end
		mem[prog_len - 1] = encode_word(op_rtype, 2'd0, 2'd0, {2'd0, 6'd29});
		group_start[prog_len - 1] = 1'b1;
		// short forward targets that never land inside a load or store group
		for (int i = 0; i < prog_len - 1; i++) begin
			if (mem[i][15:12] <= 4'd1 || mem[i][15:12] == 4'd9) begin
				t = i + 1 + int'($urandom_range(0, 7));
				if (t > prog_len - 1)
					t = prog_len - 1;
				while (!group_start[t])
					t++;
				if (mem[i][15:12] == 4'd9)
					mem[i][11:0] = 12'(t);
				else
					mem[i][7:0] = 8'(t - i - 1);
			end
		end
	endtask

	task automatic run_model();
		logic [15:0] pc;
		logic [15:0] w;
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] ea;
		logic [15:0] port;
		bit halted;
		bit last_lwd;
		int cyc;
		pc = '0;
		port = '0;
		halted = 1'b0;
		last_lwd = 1'b0;
		ref_mem = mem;
		for (int i = 0; i < 4; i++) begin
			regs[i] = '0;
		end
		while (!halted && exp_pc.size() < prog_len) begin
			w = ref_mem[pc[7:0]];
			a = regs[w[11:10]];
			b = regs[w[9:8]];
			ea = a + sign_extend(w[7:0]);
			exp_pc.push_back(pc);
			exp_word.push_back(w);
			exp_after_load.push_back(last_lwd);
			pc = pc + 16'd1;
			cyc = 4;
			case (w[15:12])
				4'd15: begin
					cyc = (w[5:0] >= 6'd28) ? 2 : 4;
					case (w[5:0])
						6'd0: regs[w[7:6]] = a + b;
						6'd1: regs[w[7:6]] = a - b;
						6'd2: regs[w[7:6]] = a & b;
						6'd3: regs[w[7:6]] = a | b;
						6'd4: regs[w[7:6]] = ~a;
						6'd28: port = a;
						default: halted = 1'b1;
					endcase
				end
				4'd4: regs[w[9:8]] = ea;
				4'd5: regs[w[9:8]] = a | {8'h00, w[7:0]};
				4'd6: regs[w[9:8]] = {w[7:0], 8'h00};
				4'd7: begin
					regs[w[9:8]] = ref_mem[ea[7:0]];
					cyc = 5;
				end
				4'd8: begin
					ref_mem[ea[7:0]] = b;
					exp_store_addr.push_back(ea);
					exp_store_data.push_back(b);
				end
				4'd9: begin
					pc = {pc[15:12], w[11:0]};
					cyc = 2;
				end
				default: begin
					// bne when bit 12 is clear, beq when set
					cyc = 3;
					if ((a == b) == w[12])
						pc = pc + sign_extend(w[7:0]);
				end
			endcase
			last_lwd = (w[15:12] == 4'd7);
			exp_cycles.push_back(cyc);
			exp_port.push_back(port);
		end
	endtask

	initial begin
		wait (reset_n);
		while (cycle_count < max_cycles) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("timeout: the program did not finish within %0d cycles", max_cycles);
		$display("Simulation finished: FAIL");
		$finish;
	end

	initial begin
		int k;
		int start;
		int cyc;
		int total_checks;
		int total_errors;
		logic [15:0] prev;
		logic [15:0] held_port;
		logic [15:0] held_addr;
		reset_n = 1'b0;
		void'($urandom(37219));
		build_program();
		run_model();
		repeat (10) @(posedge clk);
		#1 reset_n = 1'b1;
		@(negedge clk);
		expect_equal(3, "address", exp_pc[0], address);
		k = 0;
		start = 0;
		cyc = 0;
		prev = '0;
		while (k < exp_pc.size()) begin
			@(negedge clk);
			cyc++;
			if (write_m) begin
				if (exp_store_addr.size() == 0) begin
					require(1, 1'b0, "memory write with no store left in the program");
				end else begin
					expect_equal(1, "address", exp_store_addr.pop_front(), address);
					expect_equal(1, "data", exp_store_data.pop_front(), data);
				end
			end
			if (num_inst != prev) begin
				expect_equal(4, "num_inst", prev + 16'd1, num_inst);
				expect_equal(4, "num_inst gap", 16'(exp_cycles[k]), 16'(cyc - start));
				if (exp_word[k][15:12] == 4'hf && exp_word[k][5:0] == 6'd28)
					expect_equal(exp_after_load[k] ? 2 : 0, "output_port", exp_port[k], output_port);
				prev = num_inst;
				start = cyc;
				k++;
				if (k < exp_pc.size()) begin
					expect_equal(3, "read_m", 16'd1, 16'(read_m));
					expect_equal(3, "address", exp_pc[k], address);
				end
			end
		end
		require(1, exp_store_addr.size() == 0, "some stores of the program never reached memory");
		for (int t = 0; t < 5; t++) begin
			report_test(t);
		end
		expect_equal(5, "is_halted", 16'd1, 16'(is_halted));
		expect_equal(5, "num_inst", 16'(exp_pc.size()), num_inst);
		held_port = exp_port[exp_port.size() - 1];
		held_addr = address;
		repeat (20) begin
			@(negedge clk);
			expect_equal(5, "read_m", 16'd0, 16'(read_m));
			expect_equal(5, "write_m", 16'd0, 16'(write_m));
			expect_equal(5, "output_port", held_port, output_port);
			expect_equal(5, "num_inst", 16'(exp_pc.size()), num_inst);
			expect_equal(5, "address", held_addr, address);
		end
		report_test(5);
		total_checks = 0;
		total_errors = 0;
		for (int t = 0; t < 6; t++) begin
			total_checks += checks[t];
			total_errors += errors[t];
		end
		$display("%0d instructions run, %0d checks, %0d errors", exp_pc.size(), total_checks,
			total_errors);
		if (total_errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule
